// ==== snakeGame.f ====
+incdir+.
snake_pkg.sv
snakeStepTimer.sv
snakeHead.sv
snakeScore.sv
snakeSegment.sv
snakeRenderer.sv
snakeGame.sv
snakeGame_asserts.sv
snakeGame_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module snakeGame_tb -f snakeGame.f

out=$(./obj_dir/VsnakeGame_tb)
echo "$out"

if grep -qx "No errors" <<< "$out"; then
	exit 0
else
	exit 1
fi

// ==== snakeGame_vectors.txt ====
# level dir paused restart randCol randRow steps | headCol headRow score3 score2 score1 score0 gameOver
# dir is 0 up, 1 down, 2 left, 3 right; all columns decimal
3 3 0 0 5 5 1 4 3 0 0 0 0 0
3 0 0 0 5 5 1 4 2 0 0 0 0 0
3 3 0 0 10 2 5 9 2 0 0 0 1 0
3 3 0 0 11 2 1 10 2 0 0 0 2 0
3 3 0 0 12 2 1 11 2 0 0 0 3 0
3 3 0 0 13 2 1 12 2 0 0 0 4 0
3 3 0 0 14 2 1 13 2 0 0 0 5 0
3 3 0 0 15 2 1 14 2 0 0 0 6 0
3 3 0 0 16 2 1 15 2 0 0 0 7 0
3 3 0 0 17 2 1 16 2 0 0 0 8 0
3 3 0 0 18 2 1 17 2 0 0 0 9 0
3 3 0 0 20 10 1 18 2 0 0 1 0 0
0 3 0 0 20 10 6 0 2 0 0 1 0 0
0 0 0 0 20 10 3 0 18 0 0 1 0 0
0 2 0 0 20 10 1 23 18 0 0 1 0 0
0 1 0 0 20 10 1 23 0 0 0 1 0 0
0 1 1 0 20 10 3 23 0 0 0 1 0 0
2 0 0 0 20 10 1 23 0 0 0 1 0 1
2 1 0 0 20 10 2 23 0 0 0 1 0 1
2 1 0 1 20 10 1 3 3 0 0 0 0 0
3 0 0 0 1 1 1 3 2 0 0 0 0 0
3 3 0 0 1 1 6 9 2 0 0 0 1 0
3 2 0 0 1 1 1 9 2 0 0 0 1 1
3 2 0 1 1 1 1 3 3 0 0 0 0 0
1 3 0 0 1 1 2 5 3 0 0 0 0 0

// ==== snakeGame_tb.sv ====
`timescale 1ns/1ns
`include "snake_defs.svh"

module snakeGame_tb;

	import snake_pkg::*;

	localparam int ClkPerUnit = 2;
	localparam int MaxVec = 64;

	logic clk;
	logic arstN;
	dir_t dir;
	level_t level;
	logic paused;
	logic restart;
	cellCol_t randCol;
	cellRow_t randRow;
	logic [9:0] pixX;
	logic [9:0] pixY;
	logic videoOn;
	rgb_t rgb;
	cellCol_t headCol;
	cellRow_t headRow;
	logic gameOver;
	bcdDigit_t score0;
	bcdDigit_t score1;
	bcdDigit_t score2;
	bcdDigit_t score3;

	int vec [MaxVec][14];
	int numVec;
	int pLevel, pDir, pPaused, pRestart, pRandCol, pRandRow; // Applied on the next edge

	// Reference model state
	int mCnt;
	int mHeadCol, mHeadRow, mFruitCol, mFruitRow;
	int mScore;
	int mLen;
	bit mOver;
	int mSegCol [`SNAKE_SEGMENTS];
	int mSegRow [`SNAKE_SEGMENTS];
	int stepCount;

	logic [31:0] lfsr;
	int errors;
	int checks;
	longint watchLimit;
	bit watchArmed;

	snakeGame #(.ClkPerUnit(ClkPerUnit)) DUT (
		.clk(clk), .arstN(arstN), .dir(dir), .level(level), .paused(paused),
		.restart(restart), .randCol(randCol), .randRow(randRow), .pixX(pixX),
		.pixY(pixY), .videoOn(videoOn), .rgb(rgb), .headCol(headCol), .headRow(headRow),
		.gameOver(gameOver), .score0(score0), .score1(score1), .score2(score2),
		.score3(score3)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic int stepUnits(input int lv);
		case (lv)
			0: return 14;
			1: return 9;
			2: return 5;
			default: return 3;
		endcase
	endfunction

	// Taps 32, 22, 2, 1
	function automatic logic lfsrBit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic int randBits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsrBit());
		end
		return v;
	endfunction

	function automatic logic [2:0] expColour(input int x, input int y, input bit on);
		int c;
		int r;
		bit body;
		c = (x - 3) / 25;
		r = (y - 3) / 25;
		body = 0;
		for (int i = 0; i < mLen; i++) begin
			if (mSegCol[i] == c && mSegRow[i] == r) body = 1;
		end
		if (!on) return 3'b000;
		if (mOver) return 3'b001;
		if (x <= 2 || x >= 603 || y <= 2 || y >= 478) return 3'b111;
		if (c == mHeadCol && r == mHeadRow) return 3'b010;
		if (c == mFruitCol && r == mFruitRow) return 3'b100;
		if (body) return 3'b010;
		return 3'b000;
	endfunction

	task automatic modelReset();
		mHeadCol = 3;
		mHeadRow = 3;
		mFruitCol = 9;
		mFruitRow = 2;
		mScore = 0;
		mLen = 0;
		mOver = 0;
	endtask

	// One step edge of the game rules with the inputs the DUT samples now
	task automatic modelStep();
		int nc;
		int nr;
		int newLen;
		bit off;
		bit hit;
		bit ate;
		nc = mHeadCol;
		nr = mHeadRow;
		off = 0;
		hit = 0;
		if (mOver) begin
			if (restart) modelReset();
		end else if (!paused) begin
			case (dir)
				dirUp: begin
					off = (mHeadRow == 0);
					nr = off ? 18 : mHeadRow - 1;
				end
				dirDown: begin
					off = (mHeadRow == 18);
					nr = off ? 0 : mHeadRow + 1;
				end
				dirLeft: begin
					off = (mHeadCol == 0);
					nc = off ? 23 : mHeadCol - 1;
				end
				default: begin
					off = (mHeadCol == 23);
					nc = off ? 0 : mHeadCol + 1;
				end
			endcase
			for (int i = 0; i < mLen; i++) begin
				if (mSegCol[i] == nc && mSegRow[i] == nr) hit = 1;
			end
			if ((off && level >= 2) || hit) begin
				mOver = 1;
			end else begin
				ate = (nc == mFruitCol && nr == mFruitRow);
				newLen = (ate && mLen < `SNAKE_SEGMENTS) ? mLen + 1 : mLen;
				for (int i = newLen - 1; i > 0; i--) begin
					mSegCol[i] = mSegCol[i-1];
					mSegRow[i] = mSegRow[i-1];
				end
				if (newLen > 0) begin
					mSegCol[0] = mHeadCol;
					mSegRow[0] = mHeadRow;
				end
				mLen = newLen;
				mHeadCol = nc;
				mHeadRow = nr;
				if (ate) begin
					mFruitCol = int'(randCol);
					mFruitRow = int'(randRow);
					mScore = (mScore + 1) % 10000;
				end
			end
		end
	endtask

	task automatic checkVal(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s got %h expected %h at %0t ns", name, got, exp, $time);
		end
	endtask

	// Probe head, fruit, first body cell or anywhere
	task automatic pickPixel(output int px, output int py);
		int sel;
		sel = randBits(2);
		if (sel == 1) begin
			px = 3 + mHeadCol * 25 + randBits(5) % 25;
			py = 3 + mHeadRow * 25 + randBits(5) % 25;
		end else if (sel == 2) begin
			px = 3 + mFruitCol * 25 + randBits(5) % 25;
			py = 3 + mFruitRow * 25 + randBits(5) % 25;
		end else if (sel == 3 && mLen > 0) begin
			px = 3 + mSegCol[0] * 25 + randBits(5) % 25;
			py = 3 + mSegRow[0] * 25 + randBits(5) % 25;
		end else begin
			px = randBits(10) % 640;
			py = randBits(9) % 480;
		end
	endtask

	task automatic runCycle();
		logic [2:0] expRgb;
		int px;
		int py;
		@(posedge clk);
		expRgb = expColour(int'(pixX), int'(pixY), videoOn);
		if (mCnt >= ClkPerUnit * stepUnits(int'(level)) - 1) begin
			modelStep();
			mCnt = 0;
			stepCount++;
		end else begin
			mCnt++;
		end
		level <= level_t'(pLevel);
		dir <= dir_t'(pDir);
		paused <= pPaused[0];
		restart <= pRestart[0];
		randCol <= cellCol_t'(pRandCol);
		randRow <= cellRow_t'(pRandRow);
		pickPixel(px, py);
		pixX <= 10'(px);
		pixY <= 10'(py);
		videoOn <= (randBits(3) != 0);
		@(negedge clk);
		checkVal("rgb", 16'(rgb), 16'(expRgb));
		checkVal("headCol", 16'(headCol), 16'(mHeadCol));
		checkVal("headRow", 16'(headRow), 16'(mHeadRow));
		checkVal("gameOver", 16'(gameOver), 16'(mOver));
		checkVal("score", {score3, score2, score1, score0},
			16'({4'(mScore / 1000), 4'(mScore / 100 % 10), 4'(mScore / 10 % 10), 4'(mScore % 10)}));
	endtask

	task automatic loadVectors();
		int fd;
		int n;
		string line;
		int f [14];
		fd = $fopen("snakeGame_vectors.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the vector file snakeGame_vectors.txt");
			errors++;
			return;
		end
		while (!$feof(fd) && numVec < MaxVec) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line[0] == "#") continue;
			n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d",
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
				f[12], f[13]);
			if (n != 14) begin
				$display("Vector line has %0d fields instead of 14: %s", n, line);
				errors++;
				continue;
			end
			for (int i = 0; i < 14; i++) vec[numVec][i] = f[i];
			numVec++;
		end
		$fclose(fd);
	endtask

	initial begin
		wait (watchArmed);
		#(watchLimit);
		$display("Watchdog expired after %0d ns before the vectors were done", watchLimit);
		$display("Errors found");
		$finish;
	end

	initial begin
		int target;
		arstN = 1'b0;
		dir = dirRight;
		level = 2'd3;
		paused = 1'b0;
		restart = 1'b0;
		randCol = '0;
		randRow = '0;
		pixX = '0;
		pixY = '0;
		videoOn = 1'b0;
		pLevel = 3;
		pDir = 3;
		pPaused = 0;
		pRestart = 0;
		pRandCol = 0;
		pRandRow = 0;
		lfsr = 32'hd47ea13f;
		errors = 0;
		checks = 0;
		numVec = 0;
		stepCount = 0;
		mCnt = 0;
		modelReset();
		loadVectors();
		watchLimit = 2000;
		for (int v = 0; v < numVec; v++) begin
			watchLimit += longint'(vec[v][6] + 1) * ClkPerUnit * 14 * 20;
		end
		watchArmed = 1;

		repeat (3) @(posedge clk);
		arstN <= 1'b1;

		for (int v = 0; v < numVec; v++) begin
			pLevel = vec[v][0];
			pDir = vec[v][1];
			pPaused = vec[v][2];
			pRestart = vec[v][3];
			pRandCol = vec[v][4];
			pRandRow = vec[v][5];
			target = stepCount + vec[v][6];
			while (stepCount < target) runCycle();
			// Model cross-check against the file, then the DUT against the file
			checkVal($sformatf("vector %0d model headCol", v), 16'(mHeadCol), 16'(vec[v][7]));
			checkVal($sformatf("vector %0d model headRow", v), 16'(mHeadRow), 16'(vec[v][8]));
			checkVal($sformatf("vector %0d model score", v), 16'(mScore),
				16'(vec[v][9] * 1000 + vec[v][10] * 100 + vec[v][11] * 10 + vec[v][12]));
			checkVal($sformatf("vector %0d model gameOver", v), 16'(mOver), 16'(vec[v][13]));
			checkVal($sformatf("vector %0d headCol", v), 16'(headCol), 16'(vec[v][7]));
			checkVal($sformatf("vector %0d headRow", v), 16'(headRow), 16'(vec[v][8]));
			checkVal($sformatf("vector %0d score3", v), 16'(score3), 16'(vec[v][9]));
			checkVal($sformatf("vector %0d score2", v), 16'(score2), 16'(vec[v][10]));
			checkVal($sformatf("vector %0d score1", v), 16'(score1), 16'(vec[v][11]));
			checkVal($sformatf("vector %0d score0", v), 16'(score0), 16'(vec[v][12]));
			checkVal($sformatf("vector %0d gameOver", v), 16'(gameOver), 16'(vec[v][13]));
		end

		$display("Vectors %0d, checks %0d, errors %0d", numVec, checks, errors);
		if (errors == 0 && numVec > 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== snakeGame_asserts.sv ====
`timescale 1ns/1ns

module snakeGame_asserts (
	input logic clk,
	input logic arstN,
	input logic videoOn,
	input logic restart,
	input logic gameOver,
	input snake_pkg::rgb_t rgb,
	input snake_pkg::cellCol_t headCol,
	input snake_pkg::cellRow_t headRow,
	input snake_pkg::bcdDigit_t score0,
	input snake_pkg::bcdDigit_t score1,
	input snake_pkg::bcdDigit_t score2,
	input snake_pkg::bcdDigit_t score3
);

	// Blanking is registered, so black shows one cycle later
	blankRgb: assert property (@(posedge clk) disable iff (!arstN)
		!videoOn |=> rgb == 3'b000)
		else $error("rgb not black one cycle after videoOn low");

	bcdRange: assert property (@(posedge clk) disable iff (!arstN)
		score0 <= 4'd9 && score1 <= 4'd9 && score2 <= 4'd9 && score3 <= 4'd9)
		else $error("score digit outside 0 to 9");

	frozenHead: assert property (@(posedge clk) disable iff (!arstN)
		(gameOver && !restart) |=> ($stable(headCol) && $stable(headRow)))
		else $error("head moved during game over");

endmodule

bind snakeGame snakeGame_asserts asserts (
	.clk(clk), .arstN(arstN), .videoOn(videoOn), .restart(restart), .gameOver(gameOver),
	.rgb(rgb), .headCol(headCol), .headRow(headRow),
	.score0(score0), .score1(score1), .score2(score2), .score3(score3)
);

// ==== snakeGame.sv ====
`timescale 1ns/1ns
`include "snake_defs.svh"

module snakeGame #(
	parameter int ClkPerUnit = 1000000
) (
	input logic clk,
	input logic arstN,
	input snake_pkg::dir_t dir,
	input snake_pkg::level_t level,
	input logic paused,
	input logic restart,
	input snake_pkg::cellCol_t randCol,
	input snake_pkg::cellRow_t randRow,
	input logic [9:0] pixX,
	input logic [9:0] pixY,
	input logic videoOn,
	output snake_pkg::rgb_t rgb,
	output snake_pkg::cellCol_t headCol,
	output snake_pkg::cellRow_t headRow,
	output logic gameOver,
	output snake_pkg::bcdDigit_t score0,
	output snake_pkg::bcdDigit_t score1,
	output snake_pkg::bcdDigit_t score2,
	output snake_pkg::bcdDigit_t score3
);

	import snake_pkg::*;

	logic step;
	logic move;
	logic grow;
	logic eat;
	logic clear;
	cellCol_t nextCol;
	cellRow_t nextRow;
	cellCol_t fruitCol;
	cellRow_t fruitRow;
	cellCol_t pixCol;
	cellRow_t pixRow;
	logic [`SNAKE_SEGMENTS-1:0] bodyHit;
	logic [`SNAKE_SEGMENTS-1:0] pixHit;

	// Entry 0 is the head, entry i+1 is segment i
	cellCol_t chainCol [`SNAKE_SEGMENTS+1];
	cellRow_t chainRow [`SNAKE_SEGMENTS+1];
	logic [`SNAKE_SEGMENTS:0] chainValid;

	snakeStepTimer #(.ClkPerUnit(ClkPerUnit)) stepTimer (
		.clk(clk), .arstN(arstN), .level(level), .step(step)
	);

	snakeHead head (
		.clk(clk), .arstN(arstN), .step(step), .dir(dir), .level(level),
		.paused(paused), .restart(restart), .randCol(randCol), .randRow(randRow),
		.bodyHit(bodyHit), .headCol(headCol), .headRow(headRow),
		.nextCol(nextCol), .nextRow(nextRow), .fruitCol(fruitCol), .fruitRow(fruitRow),
		.move(move), .grow(grow), .eat(eat), .clear(clear), .gameOver(gameOver)
	);

	snakeScore score (
		.clk(clk), .arstN(arstN), .step(step), .eat(eat), .clear(clear),
		.score0(score0), .score1(score1), .score2(score2), .score3(score3)
	);

	assign chainCol[0] = headCol;
	assign chainRow[0] = headRow;
	assign chainValid[0] = 1'b1; // Head always present

	genvar i;
	generate
		for (i = 0; i < `SNAKE_SEGMENTS; i++) begin : gSeg
			snakeSegment segment (
				.clk(clk), .arstN(arstN), .step(move), .grow(grow), .clear(clear),
				.prevCol(chainCol[i]), .prevRow(chainRow[i]), .prevValid(chainValid[i]),
				.nextCol(nextCol), .nextRow(nextRow), .pixCol(pixCol), .pixRow(pixRow),
				.col(chainCol[i+1]), .row(chainRow[i+1]), .valid(chainValid[i+1]),
				.bodyHit(bodyHit[i]), .pixHit(pixHit[i])
			);
		end
	endgenerate

	snakeRenderer renderer (
		.clk(clk), .arstN(arstN), .pixX(pixX), .pixY(pixY), .videoOn(videoOn),
		.headCol(headCol), .headRow(headRow), .fruitCol(fruitCol), .fruitRow(fruitRow),
		.gameOver(gameOver), .pixHit(pixHit), .pixCol(pixCol), .pixRow(pixRow), .rgb(rgb)
	);

endmodule

// ==== snakeRenderer.sv ====
`timescale 1ns/1ns
`include "snake_defs.svh"

module snakeRenderer (
	input logic clk,
	input logic arstN,
	input logic [9:0] pixX,
	input logic [9:0] pixY,
	input logic videoOn,
	input snake_pkg::cellCol_t headCol,
	input snake_pkg::cellRow_t headRow,
	input snake_pkg::cellCol_t fruitCol,
	input snake_pkg::cellRow_t fruitRow,
	input logic gameOver,
	input logic [`SNAKE_SEGMENTS-1:0] pixHit,
	output snake_pkg::cellCol_t pixCol,
	output snake_pkg::cellRow_t pixRow,
	output snake_pkg::rgb_t rgb
);

	logic wall;
	logic headPix;
	logic fruitPix;
	logic [9:0] offX;
	logic [9:0] offY;
	logic [9:0] cellX;
	logic [9:0] cellY;

	// Border 3 px wide around a 600 x 475 field
	assign wall = (pixX < 10'(`SNAKE_ORIGIN))
		|| (pixX >= 10'(`SNAKE_ORIGIN + `SNAKE_COLS * `SNAKE_PITCH))
		|| (pixY < 10'(`SNAKE_ORIGIN))
		|| (pixY >= 10'(`SNAKE_ORIGIN + `SNAKE_ROWS * `SNAKE_PITCH));

	assign offX = pixX - 10'(`SNAKE_ORIGIN);
	assign offY = pixY - 10'(`SNAKE_ORIGIN);
	assign cellX = offX / 10'(`SNAKE_PITCH);
	assign cellY = offY / 10'(`SNAKE_PITCH);
	assign pixCol = cellX[4:0]; // Meaningless on wall pixels
	assign pixRow = cellY[4:0];

	assign headPix = (pixCol == headCol) && (pixRow == headRow);
	assign fruitPix = (pixCol == fruitCol) && (pixRow == fruitRow);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			rgb <= 3'b000;
		end else if (!videoOn) begin
			rgb <= 3'b000;
		end else if (gameOver) begin
			rgb <= `SNAKE_RGB_OVER;
		end else if (wall) begin
			rgb <= `SNAKE_RGB_WALL;
		end else if (headPix) begin
			rgb <= `SNAKE_RGB_SNAKE;
		end else if (fruitPix) begin
			rgb <= `SNAKE_RGB_FRUIT;
		end else if (|pixHit) begin
			rgb <= `SNAKE_RGB_SNAKE;
		end else begin
			rgb <= 3'b000;
		end
	end

endmodule

// ==== snakeSegment.sv ====
`timescale 1ns/1ns

module snakeSegment (
	input logic clk,
	input logic arstN,
	input logic step,
	input logic grow,
	input logic clear,
	input snake_pkg::cellCol_t prevCol,
	input snake_pkg::cellRow_t prevRow,
	input logic prevValid,
	input snake_pkg::cellCol_t nextCol,
	input snake_pkg::cellRow_t nextRow,
	input snake_pkg::cellCol_t pixCol,
	input snake_pkg::cellRow_t pixRow,
	output snake_pkg::cellCol_t col,
	output snake_pkg::cellRow_t row,
	output logic valid,
	output logic bodyHit,
	output logic pixHit
);

	logic take;

	// Follow the predecessor, or join as the new tail on growth
	assign take = valid || (grow && prevValid);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			valid <= 1'b0;
		end else if (clear) begin
			valid <= 1'b0;
		end else if (step && take) begin
			valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (step && take) begin
			col <= prevCol;
			row <= prevRow;
		end
	end

	assign bodyHit = valid && (col == nextCol) && (row == nextRow);
	assign pixHit = valid && (col == pixCol) && (row == pixRow);

endmodule

// ==== snakeScore.sv ====
`timescale 1ns/1ns

module snakeScore (
	input logic clk,
	input logic arstN,
	input logic step,
	input logic eat,
	input logic clear,
	output snake_pkg::bcdDigit_t score0,
	output snake_pkg::bcdDigit_t score1,
	output snake_pkg::bcdDigit_t score2,
	output snake_pkg::bcdDigit_t score3
);

	import snake_pkg::*;

	bcdDigit_t digit [4];
	logic [3:0] carry; // carry[i] bumps digit i

	assign carry[0] = eat;

	genvar i;
	generate
		for (i = 0; i < 4; i++) begin : gDigit
			if (i < 3) begin : gCarry
				assign carry[i+1] = carry[i] && (digit[i] == 4'd9);
			end

			always_ff @(posedge clk or negedge arstN) begin
				if (!arstN) begin
					digit[i] <= 4'd0;
				end else if (step) begin
					if (clear) begin
						digit[i] <= 4'd0;
					end else if (carry[i]) begin
						digit[i] <= (digit[i] == 4'd9) ? 4'd0 : digit[i] + 4'd1;
					end
				end
			end
		end
	endgenerate

	assign score0 = digit[0];
	assign score1 = digit[1];
	assign score2 = digit[2];
	assign score3 = digit[3];

endmodule

// ==== snakeHead.sv ====
`timescale 1ns/1ns
`include "snake_defs.svh"

module snakeHead (
	input logic clk,
	input logic arstN,
	input logic step,
	input snake_pkg::dir_t dir,
	input snake_pkg::level_t level,
	input logic paused,
	input logic restart,
	input snake_pkg::cellCol_t randCol,
	input snake_pkg::cellRow_t randRow,
	input logic [`SNAKE_SEGMENTS-1:0] bodyHit,
	output snake_pkg::cellCol_t headCol,
	output snake_pkg::cellRow_t headRow,
	output snake_pkg::cellCol_t nextCol,
	output snake_pkg::cellRow_t nextRow,
	output snake_pkg::cellCol_t fruitCol,
	output snake_pkg::cellRow_t fruitRow,
	output logic move,
	output logic grow,
	output logic eat,
	output logic clear,
	output logic gameOver
);

	import snake_pkg::*;

	logic offGrid;
	logic wallHit;
	logic selfHit;
	logic active;

	// Candidate cell already wrapped to the opposite edge
	always_comb begin
		nextCol = headCol;
		nextRow = headRow;
		offGrid = 1'b0;
		case (dir)
			dirUp: begin
				offGrid = (headRow == 5'd0);
				nextRow = offGrid ? 5'(`SNAKE_ROWS - 1) : headRow - 5'd1;
			end
			dirDown: begin
				offGrid = (headRow == 5'(`SNAKE_ROWS - 1));
				nextRow = offGrid ? 5'd0 : headRow + 5'd1;
			end
			dirLeft: begin
				offGrid = (headCol == 5'd0);
				nextCol = offGrid ? 5'(`SNAKE_COLS - 1) : headCol - 5'd1;
			end
			default: begin
				offGrid = (headCol == 5'(`SNAKE_COLS - 1));
				nextCol = offGrid ? 5'd0 : headCol + 5'd1;
			end
		endcase
	end

	assign wallHit = offGrid && level[1]; // Hard levels only
	assign selfHit = |bodyHit;

	assign active = step && !gameOver && !paused;
	assign move = active && !wallHit && !selfHit;
	assign eat = move && (nextCol == fruitCol) && (nextRow == fruitRow);
	assign grow = eat;
	assign clear = step && gameOver && restart;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			headCol <= 5'(`SNAKE_HEAD_COL);
			headRow <= 5'(`SNAKE_HEAD_ROW);
			fruitCol <= 5'(`SNAKE_FRUIT_COL);
			fruitRow <= 5'(`SNAKE_FRUIT_ROW);
			gameOver <= 1'b0;
		end else if (clear) begin
			headCol <= 5'(`SNAKE_HEAD_COL);
			headRow <= 5'(`SNAKE_HEAD_ROW);
			fruitCol <= 5'(`SNAKE_FRUIT_COL);
			fruitRow <= 5'(`SNAKE_FRUIT_ROW);
			gameOver <= 1'b0;
		end else if (move) begin
			headCol <= nextCol;
			headRow <= nextRow;
			if (eat) begin
				fruitCol <= randCol;
				fruitRow <= randRow;
			end
		end else if (active) begin
			gameOver <= 1'b1; // Blocked by wall or body, head stays put
		end
	end

endmodule

// ==== snakeStepTimer.sv ====
`timescale 1ns/1ns

module snakeStepTimer #(
	parameter int ClkPerUnit = 1000000
) (
	input logic clk,
	input logic arstN,
	input snake_pkg::level_t level,
	output logic step
);

	// Longest period is level 0 with 14 units
	localparam int CntW = $clog2(ClkPerUnit * 14 + 1);

	logic [CntW-1:0] cnt;
	logic [CntW-1:0] lastCnt;

	// Units per step are 14, 9, 5 and 3
	always_comb begin
		case (level)
			2'd0: lastCnt = CntW'(ClkPerUnit * 14 - 1);
			2'd1: lastCnt = CntW'(ClkPerUnit * 9 - 1);
			2'd2: lastCnt = CntW'(ClkPerUnit * 5 - 1);
			default: lastCnt = CntW'(ClkPerUnit * 3 - 1);
		endcase
	end

	// A drop to a faster level may leave cnt past the new end
	assign step = (cnt >= lastCnt);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			cnt <= '0;
		end else if (step) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

// ==== snake_pkg.sv ====
package snake_pkg;

	// Cell coordinates wide enough for the grid and the wrap compare
	typedef logic [4:0] cellCol_t;
	typedef logic [4:0] cellRow_t;

	typedef enum logic [1:0] {
		dirUp = 2'd0,
		dirDown = 2'd1,
		dirLeft = 2'd2,
		dirRight = 2'd3
	} dir_t;

	// 0 and 1 wrap at the walls, 2 and 3 end the game there
	typedef logic [1:0] level_t;

	typedef logic [2:0] rgb_t; // {r, g, b}

	typedef logic [3:0] bcdDigit_t;

endpackage

// ==== snake_defs.svh ====
`ifndef SNAKE_DEFS_SVH
`define SNAKE_DEFS_SVH

// Playfield grid
`define SNAKE_COLS 24
`define SNAKE_ROWS 19
`define SNAKE_PITCH 25 // Pixels per cell side
`define SNAKE_ORIGIN 3 // First field pixel in x and y

`define SNAKE_SEGMENTS 20

// Start cells
`define SNAKE_HEAD_COL 3
`define SNAKE_HEAD_ROW 3
`define SNAKE_FRUIT_COL 9
`define SNAKE_FRUIT_ROW 2

// Colours as {r, g, b}
`define SNAKE_RGB_WALL 3'b111
`define SNAKE_RGB_SNAKE 3'b010
`define SNAKE_RGB_FRUIT 3'b100
`define SNAKE_RGB_OVER 3'b001

`endif
